/* verilog/rename_core_settings.svh */
`ifndef RENAME_CORE_SETTINGS_SVH
`define RENAME_CORE_SETTINGS_SVH

// register file sizes
`define RC_ARCH_REGS 32
`define RC_PHYS_REGS 64

// reorder buffer entries, also the sender's starting credit
`define RC_ROB_DEPTH 16

// instructions renamed per cycle
`define RC_LANES     2

`endif

/* verilog/rename_core_pkg.sv */
`include "rename_core_settings.svh"

package rename_core_pkg;

	// architectural register index
	typedef logic [$clog2(`RC_ARCH_REGS)-1:0] areg_t;

	// physical register index
	typedef logic [$clog2(`RC_PHYS_REGS)-1:0] preg_t;

	// reorder buffer slot
	typedef logic [$clog2(`RC_ROB_DEPTH)-1:0] rob_tag_t;

	// lane count, zero up to a full group
	typedef logic [$clog2(`RC_LANES+1)-1:0] lane_cnt_t;

endpackage

/* verilog/dispatch_if.sv */
`timescale 1ns/1ps
`include "rename_core_settings.svh"

// renamed group on its way into the reorder buffer
interface dispatch_if;

	logic [`RC_LANES-1:0]   valid;
	// lane writes a real register, rd 0 does not count
	logic [`RC_LANES-1:0]   has_rd;
	rename_core_pkg::areg_t rd      [`RC_LANES];
	rename_core_pkg::preg_t prd     [`RC_LANES];
	rename_core_pkg::preg_t old_prd [`RC_LANES];

	modport rename (
		output valid, has_rd, rd, prd, old_prd
	);

	modport rob (
		input  valid, has_rd, rd, prd, old_prd
	);

endinterface

/* verilog/commit_if.sv */
`timescale 1ns/1ps
`include "rename_core_settings.svh"

// retired instructions, oldest in lane 0
interface commit_if;

	logic [`RC_LANES-1:0]   valid;
	logic [`RC_LANES-1:0]   has_rd;
	rename_core_pkg::areg_t rd      [`RC_LANES];
	rename_core_pkg::preg_t prd     [`RC_LANES];
	rename_core_pkg::preg_t old_prd [`RC_LANES];

	modport rob (
		output valid, has_rd, rd, prd, old_prd
	);

	modport sink (
		input  valid, has_rd, rd, prd, old_prd
	);

endinterface

/* verilog/rename_map.sv */
`timescale 1ns/1ps
`include "rename_core_settings.svh"

module rename_map (
	input  logic                       i_clk,
	input  logic                       i_rst_n,
	input  logic [`RC_LANES-1:0]       i_valid,
	input  rename_core_pkg::areg_t     i_rd  [`RC_LANES],
	input  rename_core_pkg::areg_t     i_rs1 [`RC_LANES],
	input  rename_core_pkg::areg_t     i_rs2 [`RC_LANES],
	input  rename_core_pkg::preg_t     i_free_head0,
	input  rename_core_pkg::preg_t     i_free_head1,
	input  rename_core_pkg::rob_tag_t  i_next_tag,
	input  logic [2*`RC_LANES-1:0]     i_busy_rs,
	output rename_core_pkg::lane_cnt_t o_pop_cnt,
	output rename_core_pkg::preg_t     o_rs_addr [2*`RC_LANES],
	output logic [`RC_LANES-1:0]       o_set_valid,
	output rename_core_pkg::preg_t     o_set_addr [`RC_LANES],
	output logic [`RC_LANES-1:0]       o_ren_valid,
	output rename_core_pkg::preg_t     o_ren_prd     [`RC_LANES],
	output rename_core_pkg::preg_t     o_ren_prs1    [`RC_LANES],
	output rename_core_pkg::preg_t     o_ren_prs2    [`RC_LANES],
	output rename_core_pkg::preg_t     o_ren_old_prd [`RC_LANES],
	output rename_core_pkg::rob_tag_t  o_ren_tag     [`RC_LANES],
	output logic [`RC_LANES-1:0]       o_ren_rdy1,
	output logic [`RC_LANES-1:0]       o_ren_rdy2,
	dispatch_if.rename                 dis
);

	rename_core_pkg::preg_t    map_table [`RC_ARCH_REGS];
	logic [`RC_LANES-1:0]      has_rd;
	rename_core_pkg::preg_t    new_prd [`RC_LANES];
	rename_core_pkg::preg_t    prs1    [`RC_LANES];
	rename_core_pkg::preg_t    prs2    [`RC_LANES];
	rename_core_pkg::preg_t    old_prd [`RC_LANES];
	logic [`RC_LANES-1:0]      rdy1;
	logic [`RC_LANES-1:0]      rdy2;
	logic                      fwd_rs1;
	logic                      fwd_rs2;
	logic                      fwd_rd;
	rename_core_pkg::rob_tag_t tag1;

	// rd 0 never allocates
	assign has_rd[0] = i_valid[0] && (i_rd[0] != '0);
	assign has_rd[1] = i_valid[1] && (i_rd[1] != '0);

	// heads are handed out in lane order
	assign new_prd[0] = has_rd[0] ? i_free_head0 : '0;
	assign new_prd[1] = !has_rd[1] ? '0 : (has_rd[0] ? i_free_head1 : i_free_head0);
	assign o_pop_cnt  = rename_core_pkg::lane_cnt_t'(has_rd[0]) +
	                    rename_core_pkg::lane_cnt_t'(has_rd[1]);

	assign o_rs_addr[0] = map_table[i_rs1[0]];
	assign o_rs_addr[1] = map_table[i_rs2[0]];
	assign o_rs_addr[2] = map_table[i_rs1[1]];
	assign o_rs_addr[3] = map_table[i_rs2[1]];

	// lane 1 sees lane 0's destination before the table does
	assign fwd_rs1 = has_rd[0] && (i_rs1[1] == i_rd[0]);
	assign fwd_rs2 = has_rd[0] && (i_rs2[1] == i_rd[0]);
	assign fwd_rd  = has_rd[0] && (i_rd[1] == i_rd[0]);

	assign prs1[0]    = o_rs_addr[0];
	assign prs2[0]    = o_rs_addr[1];
	assign prs1[1]    = fwd_rs1 ? new_prd[0] : o_rs_addr[2];
	assign prs2[1]    = fwd_rs2 ? new_prd[0] : o_rs_addr[3];
	assign old_prd[0] = map_table[i_rd[0]];
	assign old_prd[1] = fwd_rd ? new_prd[0] : map_table[i_rd[1]];

	// a forwarded source waits for lane 0's result
	assign rdy1[0] = ~i_busy_rs[0];
	assign rdy2[0] = ~i_busy_rs[1];
	assign rdy1[1] = ~fwd_rs1 & ~i_busy_rs[2];
	assign rdy2[1] = ~fwd_rs2 & ~i_busy_rs[3];

	assign o_set_valid = has_rd;
	assign o_set_addr  = new_prd;

	// lane 1 sits behind lane 0 only if lane 0 is used
	assign tag1 = i_next_tag + rename_core_pkg::rob_tag_t'(i_valid[0]);

	assign dis.valid   = i_valid;
	assign dis.has_rd  = has_rd;
	assign dis.rd      = i_rd;
	assign dis.prd     = new_prd;
	assign dis.old_prd = old_prd;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			for (int i = 0; i < `RC_ARCH_REGS; i++) begin
				map_table[i] <= rename_core_pkg::preg_t'(i);
			end
		end else begin
			if (has_rd[0]) begin
				map_table[i_rd[0]] <= new_prd[0];
			end
			// younger lane wins a shared destination
			if (has_rd[1]) begin
				map_table[i_rd[1]] <= new_prd[1];
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_ren_valid <= '0;
		end else begin
			o_ren_valid <= i_valid;
		end
	end

	always_ff @(posedge i_clk) begin
		o_ren_prd     <= new_prd;
		o_ren_prs1    <= prs1;
		o_ren_prs2    <= prs2;
		o_ren_old_prd <= old_prd;
		o_ren_tag[0]  <= i_next_tag;
		o_ren_tag[1]  <= tag1;
		o_ren_rdy1    <= rdy1;
		o_ren_rdy2    <= rdy2;
	end

endmodule

/* verilog/free_list.sv */
`timescale 1ns/1ps
`include "rename_core_settings.svh"

module free_list (
	input  logic                       i_clk,
	input  logic                       i_rst_n,
	input  rename_core_pkg::lane_cnt_t i_pop_cnt,
	commit_if.sink                     cmt,
	output rename_core_pkg::preg_t     o_head0,
	output rename_core_pkg::preg_t     o_head1
);

	localparam int DEPTH = `RC_PHYS_REGS - `RC_ARCH_REGS;
	localparam int PTR_W = $clog2(DEPTH);

	typedef logic [PTR_W-1:0] ptr_t;

	rename_core_pkg::preg_t queue [DEPTH];
	ptr_t                   rd_ptr;
	ptr_t                   rd_ptr1;
	ptr_t                   wr_ptr;
	ptr_t                   wr_ptr1;
	logic [`RC_LANES-1:0]   push;

	assign rd_ptr1 = rd_ptr + 1'b1;
	assign o_head0 = queue[rd_ptr];
	assign o_head1 = queue[rd_ptr1];

	// only lanes that overwrote a mapping give a register back
	assign push    = cmt.valid & cmt.has_rd;
	assign wr_ptr1 = wr_ptr + ptr_t'(push[0]);

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			// upper half of the physical file starts out free
			for (int i = 0; i < DEPTH; i++) begin
				queue[i] <= rename_core_pkg::preg_t'(`RC_ARCH_REGS + i);
			end
			rd_ptr <= '0;
			wr_ptr <= '0;
		end else begin
			if (push[0]) begin
				queue[wr_ptr] <= cmt.old_prd[0];
			end
			if (push[1]) begin
				queue[wr_ptr1] <= cmt.old_prd[1];
			end
			rd_ptr <= rd_ptr + ptr_t'(i_pop_cnt);
			wr_ptr <= wr_ptr1 + ptr_t'(push[1]);
		end
	end

endmodule

/* verilog/busy_table.sv */
`timescale 1ns/1ps
`include "rename_core_settings.svh"

module busy_table (
	input  logic                   i_clk,
	input  logic                   i_rst_n,
	input  rename_core_pkg::preg_t i_rd_addr [2*`RC_LANES],
	input  logic [`RC_LANES-1:0]   i_set_valid,
	input  rename_core_pkg::preg_t i_set_addr [`RC_LANES],
	input  logic                   i_clr_valid,
	input  rename_core_pkg::preg_t i_clr_addr,
	output logic [2*`RC_LANES-1:0] o_busy
);

	logic [`RC_PHYS_REGS-1:0] busy;

	// source lookups see the state before the edge
	always_comb begin
		for (int i = 0; i < 2*`RC_LANES; i++) begin
			o_busy[i] = busy[i_rd_addr[i]];
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			busy <= '0;
		end else begin
			if (i_clr_valid) begin
				busy[i_clr_addr] <= 1'b0;
			end
			// later assignment, so a set beats a clear
			for (int i = 0; i < `RC_LANES; i++) begin
				if (i_set_valid[i]) begin
					busy[i_set_addr[i]] <= 1'b1;
				end
			end
			busy[0] <= 1'b0;
		end
	end

endmodule

/* verilog/reorder_buffer.sv */
`timescale 1ns/1ps
`include "rename_core_settings.svh"

module reorder_buffer (
	input  logic                       i_clk,
	input  logic                       i_rst_n,
	dispatch_if.rob                    dis,
	input  logic                       i_wb_valid,
	input  rename_core_pkg::rob_tag_t  i_wb_tag,
	output rename_core_pkg::rob_tag_t  o_next_tag,
	output logic                       o_clr_valid,
	output rename_core_pkg::preg_t     o_clr_addr,
	commit_if.rob                      cmt,
	output rename_core_pkg::lane_cnt_t o_credit_cnt
);

	localparam int DEPTH = `RC_ROB_DEPTH;
	localparam int CNT_W = $clog2(DEPTH + 1);

	typedef logic [CNT_W-1:0] cnt_t;

	logic                       ent_has_rd  [DEPTH];
	rename_core_pkg::areg_t     ent_rd      [DEPTH];
	rename_core_pkg::preg_t     ent_prd     [DEPTH];
	rename_core_pkg::preg_t     ent_old_prd [DEPTH];
	logic [DEPTH-1:0]           complete;
	rename_core_pkg::rob_tag_t  head;
	rename_core_pkg::rob_tag_t  head1;
	rename_core_pkg::rob_tag_t  tail;
	rename_core_pkg::rob_tag_t  tail1;
	cnt_t                       count;
	logic [`RC_LANES-1:0]       do_commit;
	rename_core_pkg::lane_cnt_t n_alloc;
	rename_core_pkg::lane_cnt_t n_commit;

	assign o_next_tag = tail;
	assign head1      = head + 1'b1;
	// lane 1 goes right behind lane 0, or into the tail slot alone
	assign tail1      = tail + rename_core_pkg::rob_tag_t'(dis.valid[0]);

	assign n_alloc = rename_core_pkg::lane_cnt_t'(dis.valid[0]) +
	                 rename_core_pkg::lane_cnt_t'(dis.valid[1]);

	// in order, so lane 1 only retires alongside lane 0
	assign do_commit[0] = (count != '0) && complete[head];
	assign do_commit[1] = do_commit[0] && (count > cnt_t'(1)) && complete[head1];
	assign n_commit     = rename_core_pkg::lane_cnt_t'(do_commit[0]) +
	                      rename_core_pkg::lane_cnt_t'(do_commit[1]);

	// result is in, its register stops being busy
	assign o_clr_valid = i_wb_valid && ent_has_rd[i_wb_tag];
	assign o_clr_addr  = ent_prd[i_wb_tag];

	always_ff @(posedge i_clk) begin
		if (dis.valid[0]) begin
			ent_has_rd[tail]  <= dis.has_rd[0];
			ent_rd[tail]      <= dis.rd[0];
			ent_prd[tail]     <= dis.prd[0];
			ent_old_prd[tail] <= dis.old_prd[0];
		end
		if (dis.valid[1]) begin
			ent_has_rd[tail1]  <= dis.has_rd[1];
			ent_rd[tail1]      <= dis.rd[1];
			ent_prd[tail1]     <= dis.prd[1];
			ent_old_prd[tail1] <= dis.old_prd[1];
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			complete <= '0;
			head     <= '0;
			tail     <= '0;
			count    <= '0;
		end else begin
			if (dis.valid[0]) begin
				complete[tail] <= 1'b0;
			end
			if (dis.valid[1]) begin
				complete[tail1] <= 1'b0;
			end
			if (i_wb_valid) begin
				complete[i_wb_tag] <= 1'b1;
			end
			head  <= head + rename_core_pkg::rob_tag_t'(n_commit);
			tail  <= tail + rename_core_pkg::rob_tag_t'(n_alloc);
			count <= count + cnt_t'(n_alloc) - cnt_t'(n_commit);
		end
	end

	// commit and credit leave in the same cycle
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			cmt.valid    <= '0;
			o_credit_cnt <= '0;
		end else begin
			cmt.valid    <= do_commit;
			o_credit_cnt <= n_commit;
		end
	end

	always_ff @(posedge i_clk) begin
		cmt.has_rd[0]  <= ent_has_rd[head];
		cmt.rd[0]      <= ent_rd[head];
		cmt.prd[0]     <= ent_prd[head];
		cmt.old_prd[0] <= ent_old_prd[head];
		cmt.has_rd[1]  <= ent_has_rd[head1];
		cmt.rd[1]      <= ent_rd[head1];
		cmt.prd[1]     <= ent_prd[head1];
		cmt.old_prd[1] <= ent_old_prd[head1];
	end

endmodule

/* verilog/rename_core.sv */
`timescale 1ns/1ps
`include "rename_core_settings.svh"

module rename_core (
	input  logic                       i_clk,
	input  logic                       i_rst_n,
	input  logic [`RC_LANES-1:0]       i_valid,
	input  rename_core_pkg::areg_t     i_rd  [`RC_LANES],
	input  rename_core_pkg::areg_t     i_rs1 [`RC_LANES],
	input  rename_core_pkg::areg_t     i_rs2 [`RC_LANES],
	input  logic                       i_wb_valid,
	input  rename_core_pkg::rob_tag_t  i_wb_tag,
	output logic [`RC_LANES-1:0]       o_ren_valid,
	output rename_core_pkg::preg_t     o_ren_prd     [`RC_LANES],
	output rename_core_pkg::preg_t     o_ren_prs1    [`RC_LANES],
	output rename_core_pkg::preg_t     o_ren_prs2    [`RC_LANES],
	output rename_core_pkg::preg_t     o_ren_old_prd [`RC_LANES],
	output rename_core_pkg::rob_tag_t  o_ren_tag     [`RC_LANES],
	output logic [`RC_LANES-1:0]       o_ren_rdy1,
	output logic [`RC_LANES-1:0]       o_ren_rdy2,
	output logic [`RC_LANES-1:0]       o_commit_valid,
	output rename_core_pkg::areg_t     o_commit_rd      [`RC_LANES],
	output rename_core_pkg::preg_t     o_commit_prd     [`RC_LANES],
	output rename_core_pkg::preg_t     o_commit_old_prd [`RC_LANES],
	output rename_core_pkg::lane_cnt_t o_credit_cnt
);

	dispatch_if dis ();
	commit_if   cmt ();

	rename_core_pkg::preg_t     free_head0;
	rename_core_pkg::preg_t     free_head1;
	rename_core_pkg::lane_cnt_t pop_cnt;
	rename_core_pkg::rob_tag_t  next_tag;
	rename_core_pkg::preg_t     rs_addr [2*`RC_LANES];
	logic [2*`RC_LANES-1:0]     busy_rs;
	logic [`RC_LANES-1:0]       set_valid;
	rename_core_pkg::preg_t     set_addr [`RC_LANES];
	logic                       clr_valid;
	rename_core_pkg::preg_t     clr_addr;

	rename_map rename_map_i (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_valid(i_valid), .i_rd(i_rd), .i_rs1(i_rs1), .i_rs2(i_rs2),
		.i_free_head0(free_head0), .i_free_head1(free_head1),
		.i_next_tag(next_tag), .i_busy_rs(busy_rs),
		.o_pop_cnt(pop_cnt), .o_rs_addr(rs_addr),
		.o_set_valid(set_valid), .o_set_addr(set_addr),
		.o_ren_valid(o_ren_valid), .o_ren_prd(o_ren_prd),
		.o_ren_prs1(o_ren_prs1), .o_ren_prs2(o_ren_prs2),
		.o_ren_old_prd(o_ren_old_prd), .o_ren_tag(o_ren_tag),
		.o_ren_rdy1(o_ren_rdy1), .o_ren_rdy2(o_ren_rdy2),
		.dis(dis.rename)
	);

	free_list free_list_i (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_pop_cnt(pop_cnt),
		.cmt(cmt.sink), .o_head0(free_head0), .o_head1(free_head1)
	);

	busy_table busy_table_i (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_rd_addr(rs_addr),
		.i_set_valid(set_valid), .i_set_addr(set_addr),
		.i_clr_valid(clr_valid), .i_clr_addr(clr_addr), .o_busy(busy_rs)
	);

	reorder_buffer reorder_buffer_i (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .dis(dis.rob),
		.i_wb_valid(i_wb_valid), .i_wb_tag(i_wb_tag), .o_next_tag(next_tag),
		.o_clr_valid(clr_valid), .o_clr_addr(clr_addr),
		.cmt(cmt.rob), .o_credit_cnt(o_credit_cnt)
	);

	// retired lanes leave on plain ports
	assign o_commit_valid   = cmt.valid;
	assign o_commit_rd      = cmt.rd;
	assign o_commit_prd     = cmt.prd;
	assign o_commit_old_prd = cmt.old_prd;

endmodule

/* tb/rename_core_tb.sv */
`timescale 1ns/1ps
`include "rename_core_settings.svh"

module rename_core_tb;

	localparam int N_CYCLES = 400;
	localparam int DRAIN    = 300;

	logic                              i_clk = 1'b0;
	logic                              i_rst_n = 1'b0;
	logic [`RC_LANES-1:0]              i_valid = '0;
	rename_core_pkg::areg_t            i_rd  [`RC_LANES];
	rename_core_pkg::areg_t            i_rs1 [`RC_LANES];
	rename_core_pkg::areg_t            i_rs2 [`RC_LANES];
	logic                              i_wb_valid = 1'b0;
	rename_core_pkg::rob_tag_t         i_wb_tag = '0;
	logic [`RC_LANES-1:0]              o_ren_valid;
	rename_core_pkg::preg_t            o_ren_prd     [`RC_LANES];
	rename_core_pkg::preg_t            o_ren_prs1    [`RC_LANES];
	rename_core_pkg::preg_t            o_ren_prs2    [`RC_LANES];
	rename_core_pkg::preg_t            o_ren_old_prd [`RC_LANES];
	rename_core_pkg::rob_tag_t         o_ren_tag     [`RC_LANES];
	logic [`RC_LANES-1:0]              o_ren_rdy1;
	logic [`RC_LANES-1:0]              o_ren_rdy2;
	logic [`RC_LANES-1:0]              o_commit_valid;
	rename_core_pkg::areg_t            o_commit_rd      [`RC_LANES];
	rename_core_pkg::preg_t            o_commit_prd     [`RC_LANES];
	rename_core_pkg::preg_t            o_commit_old_prd [`RC_LANES];
	rename_core_pkg::lane_cnt_t        o_credit_cnt;

	// reference model state
	int       map_tbl [`RC_ARCH_REGS];
	bit       busy [`RC_PHYS_REGS];
	int       fl [$];
	int       rob_rd [$];
	int       rob_prd [$];
	int       rob_old [$];
	int       rob_tag [$];
	int       pend [$];
	int       tag_prd [`RC_ROB_DEPTH];
	bit       tag_has [`RC_ROB_DEPTH];
	int       wb_cyc [`RC_ROB_DEPTH];
	int       m_tail = 0;
	int       credits = `RC_ROB_DEPTH;
	int       errors = 0;
	int       cyc = 0;
	int       groups = 0;
	int       commits = 0;

	// next inputs and the outputs they should produce
	bit [1:0] nxt_valid;
	int       nxt_rd [2];
	int       nxt_rs1 [2];
	int       nxt_rs2 [2];
	bit       nxt_wb;
	int       nxt_tag;
	bit [1:0] exp_valid;
	int       exp_prd [2];
	int       exp_prs1 [2];
	int       exp_prs2 [2];
	int       exp_old [2];
	int       exp_tag [2];
	bit       exp_rdy1 [2];
	bit       exp_rdy2 [2];

	rename_core rename_core_i (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_valid(i_valid), .i_rd(i_rd), .i_rs1(i_rs1), .i_rs2(i_rs2),
		.i_wb_valid(i_wb_valid), .i_wb_tag(i_wb_tag),
		.o_ren_valid(o_ren_valid), .o_ren_prd(o_ren_prd),
		.o_ren_prs1(o_ren_prs1), .o_ren_prs2(o_ren_prs2),
		.o_ren_old_prd(o_ren_old_prd), .o_ren_tag(o_ren_tag),
		.o_ren_rdy1(o_ren_rdy1), .o_ren_rdy2(o_ren_rdy2),
		.o_commit_valid(o_commit_valid), .o_commit_rd(o_commit_rd),
		.o_commit_prd(o_commit_prd), .o_commit_old_prd(o_commit_old_prd),
		.o_credit_cnt(o_credit_cnt)
	);

	always #5 i_clk = ~i_clk;

	task automatic compare(input string name, input int lane,
		input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			errors++;
			$display("MISMATCH %s lane %0d: expected %0d, actual %0d", name, lane, exp, act);
		end
	endtask

	// mostly a handful of low registers so lanes collide
	function automatic int pick_reg();
		if ($urandom % 4 != 0) begin
			return $urandom % 6;
		end
		return $urandom % `RC_ARCH_REGS;
	endfunction

	task automatic check_outputs();
		int n;
		n = 0;
		compare("ren_valid", 0, exp_valid, o_ren_valid);
		for (int l = 0; l < 2; l++) begin
			if (exp_valid[l]) begin
				compare("ren_prd", l, exp_prd[l], o_ren_prd[l]);
				compare("ren_prs1", l, exp_prs1[l], o_ren_prs1[l]);
				compare("ren_prs2", l, exp_prs2[l], o_ren_prs2[l]);
				compare("ren_old_prd", l, exp_old[l], o_ren_old_prd[l]);
				compare("ren_tag", l, exp_tag[l], o_ren_tag[l]);
				compare("ren_rdy1", l, exp_rdy1[l], o_ren_rdy1[l]);
				compare("ren_rdy2", l, exp_rdy2[l], o_ren_rdy2[l]);
			end
		end
		// retirement must follow dispatch order
		for (int l = 0; l < 2; l++) begin
			if (o_commit_valid[l]) begin
				n++;
				if (rob_tag.size() == 0) begin
					errors++;
					$display("commit on lane %0d with no instruction in flight", l);
				end else begin
					compare("commit_rd", l, rob_rd[0], o_commit_rd[l]);
					compare("commit_prd", l, rob_prd[0], o_commit_prd[l]);
					compare("commit_old_prd", l, rob_old[0], o_commit_old_prd[l]);
					if (wb_cyc[rob_tag[0]] < 0 || cyc - wb_cyc[rob_tag[0]] < 2) begin
						errors++;
						$display("tag %0d committed before its writeback", rob_tag[0]);
					end
					if (rob_rd[0] != 0) begin
						fl.push_back(rob_old[0]);
					end
					void'(rob_rd.pop_front());
					void'(rob_prd.pop_front());
					void'(rob_old.pop_front());
					void'(rob_tag.pop_front());
				end
			end
		end
		compare("credit_cnt", 0, n, o_credit_cnt);
		credits += o_credit_cnt;
		commits += n;
		if (credits > `RC_ROB_DEPTH) begin
			errors++;
			$display("core returned more credits than were spent");
		end
	endtask

	task automatic step_model();
		bit has [2];
		bit fwd1;
		bit fwd2;
		has[0] = nxt_valid[0] && nxt_rd[0] != 0;
		has[1] = nxt_valid[1] && nxt_rd[1] != 0;
		exp_valid = nxt_valid;
		for (int l = 0; l < 2; l++) begin
			exp_prd[l] = has[l] ? fl.pop_front() : 0;
		end
		fwd1 = has[0] && nxt_rs1[1] == nxt_rd[0];
		fwd2 = has[0] && nxt_rs2[1] == nxt_rd[0];
		exp_prs1[0] = map_tbl[nxt_rs1[0]];
		exp_prs2[0] = map_tbl[nxt_rs2[0]];
		exp_prs1[1] = fwd1 ? exp_prd[0] : map_tbl[nxt_rs1[1]];
		exp_prs2[1] = fwd2 ? exp_prd[0] : map_tbl[nxt_rs2[1]];
		exp_old[0] = map_tbl[nxt_rd[0]];
		exp_old[1] = (has[0] && nxt_rd[1] == nxt_rd[0]) ? exp_prd[0] : map_tbl[nxt_rd[1]];
		exp_rdy1[0] = !busy[exp_prs1[0]];
		exp_rdy2[0] = !busy[exp_prs2[0]];
		exp_rdy1[1] = !fwd1 && !busy[exp_prs1[1]];
		exp_rdy2[1] = !fwd2 && !busy[exp_prs2[1]];
		// clear first so a same-cycle set wins
		if (nxt_wb) begin
			wb_cyc[nxt_tag] = cyc;
			if (tag_has[nxt_tag]) begin
				busy[tag_prd[nxt_tag]] = 1'b0;
			end
		end
		for (int l = 0; l < 2; l++) begin
			if (has[l]) begin
				busy[exp_prd[l]] = 1'b1;
				map_tbl[nxt_rd[l]] = exp_prd[l];
			end
			if (nxt_valid[l]) begin
				exp_tag[l] = m_tail;
				tag_prd[m_tail] = exp_prd[l];
				tag_has[m_tail] = has[l];
				wb_cyc[m_tail] = -1;
				rob_rd.push_back(has[l] ? nxt_rd[l] : 0);
				rob_prd.push_back(exp_prd[l]);
				rob_old.push_back(exp_old[l]);
				rob_tag.push_back(m_tail);
				pend.push_back(m_tail);
				m_tail = (m_tail + 1) % `RC_ROB_DEPTH;
			end
		end
	endtask

	task automatic pick_stimulus(input bit send);
		int n;
		int idx;
		bit zero_rd;
		n = send ? $urandom % 3 : 0;
		if (n > credits) begin
			n = credits;
		end
		credits -= n;
		if (n > 0) begin
			groups++;
		end
		nxt_valid = (n == 2) ? 2'b11 : ((n == 1) ? 2'b01 : 2'b00);
		zero_rd = ($urandom % 8) == 0;
		for (int l = 0; l < 2; l++) begin
			nxt_rd[l] = zero_rd ? 0 : pick_reg();
			nxt_rs1[l] = pick_reg();
			nxt_rs2[l] = pick_reg();
		end
		nxt_wb = 1'b0;
		if (pend.size() > 0 && $urandom % 2 == 1) begin
			idx = $urandom % pend.size();
			nxt_wb = 1'b1;
			nxt_tag = pend[idx];
			pend.delete(idx);
		end
	endtask

	task automatic run_cycle(input bit send);
		@(posedge i_clk);
		i_valid <= nxt_valid;
		for (int l = 0; l < 2; l++) begin
			i_rd[l] <= rename_core_pkg::areg_t'(nxt_rd[l]);
			i_rs1[l] <= rename_core_pkg::areg_t'(nxt_rs1[l]);
			i_rs2[l] <= rename_core_pkg::areg_t'(nxt_rs2[l]);
		end
		i_wb_valid <= nxt_wb;
		i_wb_tag <= rename_core_pkg::rob_tag_t'(nxt_tag);
		@(negedge i_clk);
		cyc++;
		check_outputs();
		step_model();
		pick_stimulus(send);
	endtask

	initial begin
		void'($urandom(32'h3ea1));
		for (int l = 0; l < 2; l++) begin
			i_rd[l] = '0;
			i_rs1[l] = '0;
			i_rs2[l] = '0;
		end
		for (int r = 0; r < `RC_ARCH_REGS; r++) begin
			map_tbl[r] = r;
		end
		for (int p = `RC_ARCH_REGS; p < `RC_PHYS_REGS; p++) begin
			fl.push_back(p);
		end
		repeat (8) @(posedge i_clk);
		i_rst_n <= 1'b1;
		@(negedge i_clk);
		// idle core after reset
		compare("reset ren_valid", 0, 0, o_ren_valid);
		compare("reset commit_valid", 0, 0, o_commit_valid);
		compare("reset credit_cnt", 0, 0, o_credit_cnt);
		pick_stimulus(1'b1);
		repeat (N_CYCLES) run_cycle(1'b1);
		// stop sending and let every outstanding entry retire
		while (credits != `RC_ROB_DEPTH || rob_tag.size() != 0) begin
			run_cycle(1'b0);
		end
		// drained core stays quiet, no stray commits or credits
		repeat (4) run_cycle(1'b0);
		$display("cycles %0d, groups %0d, commits %0d, errors %0d", cyc, groups, commits, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	// generous bound per cycle of traffic plus the drain
	initial begin
		#((N_CYCLES * 20 + DRAIN) * 10);
		$display("timeout: core did not drain after %0d cycles, errors %0d", cyc, errors);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

/* rename_core.f */
+incdir+verilog
verilog/rename_core_pkg.sv
verilog/dispatch_if.sv
verilog/commit_if.sv
verilog/rename_map.sv
verilog/free_list.sv
verilog/busy_table.sv
verilog/reorder_buffer.sv
verilog/rename_core.sv
tb/rename_core_tb.sv
